//--- decodeStage.f
source/mipsDecodePkg.sv
source/decodeBuffer.sv
source/decodeController.sv
source/hazardTracker.sv
source/executeRegister.sv
source/decodeStage.sv
dv/decodeStage_assert.sv
dv/decodeStageTb.sv

//--- Bender.yml
package:
  name: decodeStage

sources:
  - source/mipsDecodePkg.sv
  - source/decodeBuffer.sv
  - source/decodeController.sv
  - source/hazardTracker.sv
  - source/executeRegister.sv
  - source/decodeStage.sv
  - target: test
    files:
      - dv/decodeStage_assert.sv
      - dv/decodeStageTb.sv

//--- dv/decodeStageTb.sv
module decodeStageTb;

    import mipsDecodePkg::*;

    typedef struct packed {
        logic [31:0] instr;
        logic [4:0]  aluop;
        logic        rfwe;
        logic        dmwe;
        logic [2:0]  npcop;
        logic [1:0]  wdsel;
        logic [4:0]  writeReg;
        logic [1:0]  extop;
        logic [1:0]  bsel;
        logic [3:0]  cmpop;
        logic [31:0] stalls;
    } stimRow_t;

    localparam int numRows     = 32;
    localparam int resetCycles = 16;
    localparam int cycleLimit  = 40 * numRows + resetCycles;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic        instrValid;
    logic        stall;
    logic        execValid;
    logic [2:0]  execNpcop;
    logic        execRfwe;
    logic        execDmwe;
    logic [1:0]  execExtop;
    logic [1:0]  execAsel;
    logic [1:0]  execBsel;
    logic [1:0]  execWdsel;
    logic [1:0]  execDmtype;
    logic [3:0]  execCmpop;
    logic [4:0]  execAluop;
    logic [4:0]  execWriteReg;

    stimRow_t stimTable [numRows];
    string    rowName [numRows];
    int       rowCount;
    int       validCount;
    int       cycleCount;

    decodeStage UUT (
        .clk(clk), .rst(rst), .instr(instr), .instrValid(instrValid), .stall(stall),
        .execValid(execValid), .execNpcop(execNpcop), .execRfwe(execRfwe),
        .execDmwe(execDmwe), .execExtop(execExtop), .execAsel(execAsel),
        .execBsel(execBsel), .execWdsel(execWdsel), .execDmtype(execDmtype),
        .execCmpop(execCmpop), .execAluop(execAluop), .execWriteReg(execWriteReg)
    );

    function automatic logic [31:0] rWord(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jWord(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    task automatic addRow(input string name, input logic [31:0] word, input logic [4:0] alu,
                          input logic we, input logic dwe, input logic [2:0] npc,
                          input logic [1:0] wd, input logic [4:0] wr, input logic [1:0] ext,
                          input logic [1:0] bs, input logic [3:0] cmp, input int stalls);
        stimTable[rowCount].instr    = word;
        stimTable[rowCount].aluop    = alu;
        stimTable[rowCount].rfwe     = we;
        stimTable[rowCount].dmwe     = dwe;
        stimTable[rowCount].npcop    = npc;
        stimTable[rowCount].wdsel    = wd;
        stimTable[rowCount].writeReg = wr;
        stimTable[rowCount].extop    = ext;
        stimTable[rowCount].bsel     = bs;
        stimTable[rowCount].cmpop    = cmp;
        stimTable[rowCount].stalls   = stalls;
        rowName[rowCount] = name;
        rowCount++;
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected 0x%0h actual 0x%0h", testName, expected, actual);
            $display("TB FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic expectBubble(input string testName);
        checkValue({testName, " bubble execValid"}, 32'd0, execValid);
        checkValue({testName, " bubble execRfwe"}, 32'd0, execRfwe);
        checkValue({testName, " bubble execDmwe"}, 32'd0, execDmwe);
        checkValue({testName, " bubble execAluop"}, 32'd0, execAluop);
        checkValue({testName, " bubble execNpcop"}, 32'd0, execNpcop);
        checkValue({testName, " bubble execWriteReg"}, 32'd0, execWriteReg);
        checkValue({testName, " bubble execWdsel"}, 32'd0, execWdsel);
        checkValue({testName, " bubble execExtop"}, 32'd0, execExtop);
        checkValue({testName, " bubble execBsel"}, 32'd0, execBsel);
        checkValue({testName, " bubble execCmpop"}, 32'd0, execCmpop);
    endtask

    task automatic matchExecRow(input int idx);
        string name;
        name = rowName[idx];
        checkValue({name, " execValid"}, 32'd1, execValid);
        checkValue({name, " aluop"}, stimTable[idx].aluop, execAluop);
        checkValue({name, " rfwe"}, stimTable[idx].rfwe, execRfwe);
        checkValue({name, " dmwe"}, stimTable[idx].dmwe, execDmwe);
        checkValue({name, " npcop"}, stimTable[idx].npcop, execNpcop);
        checkValue({name, " wdsel"}, stimTable[idx].wdsel, execWdsel);
        checkValue({name, " writeReg"}, stimTable[idx].writeReg, execWriteReg);
        checkValue({name, " extop"}, stimTable[idx].extop, execExtop);
        checkValue({name, " bsel"}, stimTable[idx].bsel, execBsel);
        checkValue({name, " cmpop"}, stimTable[idx].cmpop, execCmpop);
        checkValue({name, " asel"}, 32'd0, execAsel);  // A operand is always rs
        checkValue({name, " dmtype"}, 32'd0, execDmtype);  // Word accesses only
    endtask

    // Stall counts follow tnew minus distance against tuse
    task automatic buildTable();
        rowCount = 0;
        addRow("addu", rWord(5'd1, 5'd2, 5'd3, fnAddu), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd0, 5'd3, 2'd0, 2'd0, cmpNone, 0);
        addRow("subu", rWord(5'd4, 5'd5, 5'd6, fnSubu), aluSub, 1'b1, 1'b0, npcSeq,
               2'd0, 5'd6, 2'd0, 2'd0, cmpNone, 0);
        addRow("ori", iWord(opOri, 5'd7, 5'd8, 16'h1234), aluOr, 1'b1, 1'b0, npcSeq,
               2'd0, 5'd8, 2'd0, 2'd1, cmpNone, 0);  // Zero-extended immediate
        addRow("lui", iWord(opLui, 5'd0, 5'd9, 16'habcd), aluLui, 1'b1, 1'b0, npcSeq,
               2'd0, 5'd9, 2'd0, 2'd1, cmpNone, 0);
        addRow("sw", iWord(opSw, 5'd11, 5'd10, 16'h4), aluAdd, 1'b0, 1'b1, npcSeq,
               2'd0, 5'd0, 2'd1, 2'd1, cmpNone, 0);
        addRow("lw", iWord(opLw, 5'd13, 5'd12, 16'h8), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd1, 5'd12, 2'd1, 2'd1, cmpNone, 0);
        addRow("beq", iWord(opBeq, 5'd14, 5'd15, 16'hfffc), aluNone, 1'b0, 1'b0, npcBranch,
               2'd0, 5'd0, 2'd1, 2'd0, cmpEqual, 0);
        addRow("j", jWord(opJ, 26'h100), aluNone, 1'b0, 1'b0, npcJump,
               2'd0, 5'd0, 2'd0, 2'd0, cmpNone, 0);
        addRow("jal", jWord(opJal, 26'h200), aluNone, 1'b1, 1'b0, npcJump,
               2'd2, 5'd31, 2'd0, 2'd0, cmpNone, 0);
        addRow("jr", rWord(5'd16, 5'd0, 5'd0, fnJr), aluNone, 1'b0, 1'b0, npcReg,
               2'd0, 5'd0, 2'd0, 2'd0, cmpNone, 0);
        addRow("nop", 32'h0, aluNone, 1'b0, 1'b0, npcSeq,
               2'd0, 5'd0, 2'd0, 2'd0, cmpNone, 0);
        addRow("unknown op", iWord(6'h3f, 5'd1, 5'd3, 16'h0), aluNone, 1'b0, 1'b0, npcSeq,
               2'd0, 5'd0, 2'd0, 2'd0, cmpNone, 0);
        addRow("lw r20", iWord(opLw, 5'd1, 5'd20, 16'h0), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd1, 5'd20, 2'd1, 2'd1, cmpNone, 0);
        addRow("addu uses lw", rWord(5'd20, 5'd2, 5'd21, fnAddu), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd0, 5'd21, 2'd0, 2'd0, cmpNone, 1);  // Remaining 2 then 1
        addRow("lw r22", iWord(opLw, 5'd3, 5'd22, 16'h0), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd1, 5'd22, 2'd1, 2'd1, cmpNone, 0);
        addRow("ori gap", iWord(opOri, 5'd4, 5'd23, 16'h1), aluOr, 1'b1, 1'b0, npcSeq,
               2'd0, 5'd23, 2'd0, 2'd1, cmpNone, 0);
        addRow("addu after gap", rWord(5'd22, 5'd5, 5'd24, fnAddu), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd0, 5'd24, 2'd0, 2'd0, cmpNone, 0);
        addRow("lw r25", iWord(opLw, 5'd6, 5'd25, 16'h0), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd1, 5'd25, 2'd1, 2'd1, cmpNone, 0);
        addRow("ori gap 2", iWord(opOri, 5'd7, 5'd26, 16'h2), aluOr, 1'b1, 1'b0, npcSeq,
               2'd0, 5'd26, 2'd0, 2'd1, cmpNone, 0);
        addRow("beq after gap", iWord(opBeq, 5'd25, 5'd0, 16'h4), aluNone, 1'b0, 1'b0, npcBranch,
               2'd0, 5'd0, 2'd1, 2'd0, cmpEqual, 1);  // tuse 0 against remaining 1
        addRow("lw r27", iWord(opLw, 5'd8, 5'd27, 16'h0), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd1, 5'd27, 2'd1, 2'd1, cmpNone, 0);
        addRow("beq uses lw", iWord(opBeq, 5'd27, 5'd27, 16'h8), aluNone, 1'b0, 1'b0, npcBranch,
               2'd0, 5'd0, 2'd1, 2'd0, cmpEqual, 2);
        addRow("addu r28", rWord(5'd1, 5'd2, 5'd28, fnAddu), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd0, 5'd28, 2'd0, 2'd0, cmpNone, 0);
        addRow("addu uses addu", rWord(5'd28, 5'd28, 5'd29, fnAddu), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd0, 5'd29, 2'd0, 2'd0, cmpNone, 0);
        addRow("beq uses addu", iWord(opBeq, 5'd29, 5'd0, 16'h4), aluNone, 1'b0, 1'b0, npcBranch,
               2'd0, 5'd0, 2'd1, 2'd0, cmpEqual, 1);
        addRow("lw r0", iWord(opLw, 5'd1, 5'd0, 16'h0), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd1, 5'd0, 2'd1, 2'd1, cmpNone, 0);
        addRow("addu reads r0", rWord(5'd0, 5'd0, 5'd5, fnAddu), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd0, 5'd5, 2'd0, 2'd0, cmpNone, 0);
        addRow("jal ra", jWord(opJal, 26'h300), aluNone, 1'b1, 1'b0, npcJump,
               2'd2, 5'd31, 2'd0, 2'd0, cmpNone, 0);
        addRow("jr ra", rWord(5'd31, 5'd0, 5'd0, fnJr), aluNone, 1'b0, 1'b0, npcReg,
               2'd0, 5'd0, 2'd0, 2'd0, cmpNone, 0);  // jal result already floored to 0
        addRow("lw r30", iWord(opLw, 5'd2, 5'd30, 16'h0), aluAdd, 1'b1, 1'b0, npcSeq,
               2'd1, 5'd30, 2'd1, 2'd1, cmpNone, 0);
        addRow("j over r30", jWord(opJ, {5'd30, 5'd30, 16'h0}), aluNone, 1'b0, 1'b0, npcJump,
               2'd0, 5'd0, 2'd0, 2'd0, cmpNone, 0);
        addRow("jal over r30", jWord(opJal, {5'd30, 5'd30, 16'h4}), aluNone, 1'b1, 1'b0, npcJump,
               2'd2, 5'd31, 2'd0, 2'd0, cmpNone, 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("TB FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        wait (UUT.stageChecks.failCount != 0);
        $display("A decode stage assertion failed");
        $display("TB FAILED");
        $fatal(1, "Assertion failure");
    end

    // Each accepted instruction must reach execute exactly once
    initial begin
        validCount = 0;
        forever begin
            @(negedge clk);
            if (execValid === 1'b1) begin
                validCount++;
            end
        end
    end

    initial begin
        int i;
        int stallCount;
        rst        = 1'b1;
        instr      = 32'd0;
        instrValid = 1'b0;
        buildTable();
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("reset execValid", 32'd0, execValid);
        checkValue("reset execRfwe", 32'd0, execRfwe);
        checkValue("reset execDmwe", 32'd0, execDmwe);
        checkValue("reset stall", 32'd0, stall);
        @(posedge clk);
        for (i = 0; i <= numRows + 1; i++) begin
            if (i < numRows) begin
                instr      <= stimTable[i].instr;
                instrValid <= 1'b1;
            end else begin
                instr      <= 32'd0;
                instrValid <= 1'b0;
            end
            stallCount = 0;
            @(negedge clk);
            if (i >= 2) begin
                matchExecRow(i - 2);  // Row i-2 left decode on the last edge
            end
            while (stall) begin
                stallCount++;
                @(negedge clk);
                expectBubble(rowName[i - 1]);
            end
            if (i >= 1 && i <= numRows) begin
                checkValue({rowName[i - 1], " stall cycles"}, stimTable[i - 1].stalls,
                           stallCount);
            end
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        checkValue("exec appearances", numRows, validCount);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- dv/decodeStage_assert.sv
module decodeStageAssert (
    input logic        clk,
    input logic        rst,
    input logic        stall,
    input logic        validD,
    input logic [31:0] instrD,
    input logic        execValid,
    input logic        execRfwe,
    input logic        execDmwe,
    input logic [4:0]  execAluop,
    input logic [2:0]  execNpcop,
    input logic [4:0]  execWriteReg
);

    int failCount = 0;

    stallBubble: assert property (@(posedge clk) disable iff (rst)
        stall |=> !execValid && !execRfwe && !execDmwe && execAluop == 5'd0
            && execNpcop == 3'd0 && execWriteReg == 5'd0)
        else begin
            $error("Exec outputs are not a bubble after a stall cycle");
            failCount++;
        end

    resetClears: assert property (@(posedge clk) rst |=> !execValid)
        else begin
            $error("execValid high in the cycle after reset");
            failCount++;
        end

    bufferHold: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(instrD) && $stable(validD))
        else begin
            $error("Decode buffer changed while stalled");
            failCount++;
        end

endmodule

bind decodeStage decodeStageAssert stageChecks (
    .clk(clk), .rst(rst), .stall(stall), .validD(validD), .instrD(instrD),
    .execValid(execValid), .execRfwe(execRfwe), .execDmwe(execDmwe),
    .execAluop(execAluop), .execNpcop(execNpcop), .execWriteReg(execWriteReg)
);

//--- source/decodeStage.sv
module decodeStage (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    input  logic        instrValid,
    output logic        stall,
    output logic        execValid,
    output logic [2:0]  execNpcop,
    output logic        execRfwe,
    output logic        execDmwe,
    output logic [1:0]  execExtop,
    output logic [1:0]  execAsel,
    output logic [1:0]  execBsel,
    output logic [1:0]  execWdsel,
    output logic [1:0]  execDmtype,
    output logic [3:0]  execCmpop,
    output logic [4:0]  execAluop,
    output logic [4:0]  execWriteReg
);

    import mipsDecodePkg::*;

    instrWord_t instrD;
    logic       validD;
    logic [2:0] npcop;
    logic       rfwe;
    logic       dmwe;
    logic [1:0] extop;
    logic [1:0] asel;
    logic [1:0] bsel;
    logic [1:0] wdsel;
    logic [1:0] dmtype;
    logic [3:0] cmpop;
    logic [4:0] aluop;
    logic [2:0] tuseRs;
    logic [2:0] tuseRt;
    logic [2:0] tnew;
    logic [4:0] writeReg;
    logic [4:0] writeRegE;
    logic [2:0] tnewE;

    decodeBuffer buffer (
        .clk(clk), .rst(rst), .instr(instr), .instrValid(instrValid),
        .stall(stall), .instrD(instrD), .validD(validD)
    );

    decodeController controller (
        .instrD(instrD), .validD(validD), .npcop(npcop), .rfwe(rfwe), .dmwe(dmwe),
        .extop(extop), .asel(asel), .bsel(bsel), .wdsel(wdsel), .dmtype(dmtype),
        .cmpop(cmpop), .aluop(aluop), .tuseRs(tuseRs), .tuseRt(tuseRt),
        .tnew(tnew), .writeReg(writeReg)
    );

    hazardTracker tracker (
        .clk(clk), .rst(rst), .instrD(instrD), .validD(validD), .tuseRs(tuseRs),
        .tuseRt(tuseRt), .writeRegE(writeRegE), .tnewE(tnewE), .stall(stall)
    );

    executeRegister execReg (
        .clk(clk), .rst(rst), .stall(stall), .validD(validD), .npcop(npcop),
        .rfwe(rfwe), .dmwe(dmwe), .extop(extop), .asel(asel), .bsel(bsel),
        .wdsel(wdsel), .dmtype(dmtype), .cmpop(cmpop), .aluop(aluop), .tnew(tnew),
        .writeReg(writeReg), .execValid(execValid), .execNpcop(execNpcop),
        .execRfwe(execRfwe), .execDmwe(execDmwe), .execExtop(execExtop),
        .execAsel(execAsel), .execBsel(execBsel), .execWdsel(execWdsel),
        .execDmtype(execDmtype), .execCmpop(execCmpop), .execAluop(execAluop),
        .execWriteReg(execWriteReg), .writeRegE(writeRegE), .tnewE(tnewE)
    );

endmodule

//--- source/executeRegister.sv
module executeRegister (
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  logic       validD,
    input  logic [2:0] npcop,
    input  logic       rfwe,
    input  logic       dmwe,
    input  logic [1:0] extop,
    input  logic [1:0] asel,
    input  logic [1:0] bsel,
    input  logic [1:0] wdsel,
    input  logic [1:0] dmtype,
    input  logic [3:0] cmpop,
    input  logic [4:0] aluop,
    input  logic [2:0] tnew,
    input  logic [4:0] writeReg,
    output logic       execValid,
    output logic [2:0] execNpcop,
    output logic       execRfwe,
    output logic       execDmwe,
    output logic [1:0] execExtop,
    output logic [1:0] execAsel,
    output logic [1:0] execBsel,
    output logic [1:0] execWdsel,
    output logic [1:0] execDmtype,
    output logic [3:0] execCmpop,
    output logic [4:0] execAluop,
    output logic [4:0] execWriteReg,
    output logic [4:0] writeRegE,
    output logic [2:0] tnewE
);

    always_ff @(posedge clk) begin
        if (rst || stall) begin  // Stall inserts a bubble
            execValid    <= 1'b0;
            execNpcop    <= 3'd0;
            execRfwe     <= 1'b0;
            execDmwe     <= 1'b0;
            execExtop    <= 2'd0;
            execAsel     <= 2'd0;
            execBsel     <= 2'd0;
            execWdsel    <= 2'd0;
            execDmtype   <= 2'd0;
            execCmpop    <= 4'd0;
            execAluop    <= 5'd0;
            execWriteReg <= 5'd0;
            tnewE        <= 3'd0;
        end else begin
            execValid    <= validD;
            execNpcop    <= npcop;
            execRfwe     <= rfwe;
            execDmwe     <= dmwe;
            execExtop    <= extop;
            execAsel     <= asel;
            execBsel     <= bsel;
            execWdsel    <= wdsel;
            execDmtype   <= dmtype;
            execCmpop    <= cmpop;
            execAluop    <= aluop;
            execWriteReg <= writeReg;
            tnewE        <= tnew;
        end
    end

    assign writeRegE = execWriteReg;  // Execute writer back to the tracker

endmodule

//--- source/hazardTracker.sv
module hazardTracker (
    input  logic                     clk,
    input  logic                     rst,
    input  mipsDecodePkg::instrWord_t instrD,
    input  logic                     validD,
    input  logic [2:0]               tuseRs,
    input  logic [2:0]               tuseRt,
    input  logic [4:0]               writeRegE,
    input  logic [2:0]               tnewE,
    output logic                     stall
);

    import mipsDecodePkg::*;

    logic [4:0] writeRegM;
    logic [2:0] tnewM;
    logic [2:0] remainE;
    logic [2:0] remainM;
    logic       hazardRs;
    logic       hazardRt;

    // Memory-stage writer follows the execute register by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            writeRegM <= 5'd0;
            tnewM     <= 3'd0;
        end else begin
            writeRegM <= writeRegE;
            tnewM     <= tnewE;
        end
    end

    // Remaining cycles until each writer's result exists, floored at zero
    assign remainE = (tnewE > 3'd1) ? tnewE - 3'd1 : 3'd0;
    assign remainM = (tnewM > 3'd2) ? tnewM - 3'd2 : 3'd0;

    function automatic logic srcHazard(
        input logic [4:0] src,
        input logic [2:0] tuse,
        input logic [4:0] regE,
        input logic [2:0] remE,
        input logic [4:0] regM,
        input logic [2:0] remM
    );
        logic hitE;
        logic hitM;
        hitE = (src == regE) && (tuse < remE);
        hitM = (src == regM) && (tuse < remM);
        return (src != 5'd0) && (hitE || hitM);
    endfunction

    assign hazardRs = srcHazard(instrD.r.rs, tuseRs, writeRegE, remainE,
                                writeRegM, remainM);
    assign hazardRt = srcHazard(instrD.i.rt, tuseRt, writeRegE, remainE,
                                writeRegM, remainM);

    assign stall = validD & (hazardRs | hazardRt);

endmodule

//--- source/decodeController.sv
module decodeController (
    input  mipsDecodePkg::instrWord_t instrD,
    input  logic                     validD,
    output logic [2:0]               npcop,
    output logic                     rfwe,
    output logic                     dmwe,
    output logic [1:0]               extop,
    output logic [1:0]               asel,
    output logic [1:0]               bsel,
    output logic [1:0]               wdsel,
    output logic [1:0]               dmtype,
    output logic [3:0]               cmpop,
    output logic [4:0]               aluop,
    output logic [2:0]               tuseRs,
    output logic [2:0]               tuseRt,
    output logic [2:0]               tnew,
    output logic [4:0]               writeReg
);

    import mipsDecodePkg::*;

    logic [1:0] wrSel;

    always_comb begin
        npcop  = npcSeq;  // Defaults decode as nop
        rfwe   = 1'b0;
        dmwe   = 1'b0;
        extop  = 2'd0;
        asel   = 2'd0;
        bsel   = 2'd0;
        wdsel  = 2'd0;
        dmtype = 2'd0;
        cmpop  = cmpNone;
        aluop  = aluNone;
        tuseRs = tuseNever;
        tuseRt = tuseNever;
        tnew   = 3'd0;
        wrSel  = wrSelRt;
        if (validD) begin
            case (instrD.r.op)
                opAddr: begin
                    case (instrD.r.funct)
                        fnAddu, fnSubu: begin
                            rfwe   = 1'b1;
                            wrSel  = wrSelRd;
                            aluop  = (instrD.r.funct == fnSubu) ? aluSub : aluAdd;
                            tnew   = 3'd2;
                            tuseRs = 3'd1;
                            tuseRt = 3'd1;
                        end
                        fnJr: begin
                            npcop  = npcReg;
                            tuseRs = 3'd0;  // Target needed in decode
                        end
                        default: ;
                    endcase
                end
                opOri: begin
                    rfwe   = 1'b1;
                    bsel   = 2'd1;
                    aluop  = aluOr;
                    tnew   = 3'd2;
                    tuseRs = 3'd1;
                end
                opLui: begin
                    rfwe  = 1'b1;
                    bsel  = 2'd1;
                    aluop = aluLui;
                    tnew  = 3'd2;
                end
                opLw: begin
                    rfwe   = 1'b1;
                    extop  = 2'd1;
                    bsel   = 2'd1;
                    wdsel  = 2'd1;  // Memory data
                    aluop  = aluAdd;
                    tnew   = 3'd3;
                    tuseRs = 3'd1;
                end
                opSw: begin
                    dmwe   = 1'b1;
                    extop  = 2'd1;
                    bsel   = 2'd1;
                    aluop  = aluAdd;
                    tuseRs = 3'd1;
                    tuseRt = 3'd2;  // Store data read late
                end
                opBeq: begin
                    npcop  = npcBranch;
                    extop  = 2'd1;
                    cmpop  = cmpEqual;
                    tuseRs = 3'd0;
                    tuseRt = 3'd0;
                end
                opJ: begin
                    npcop = npcJump;
                end
                opJal: begin
                    npcop = npcJump;
                    rfwe  = 1'b1;
                    wrSel = wrSelRa;
                    wdsel = 2'd2;  // Return address
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (wrSel)
            wrSelRd: writeReg = instrD.r.rd;
            wrSelRa: writeReg = raReg;
            default: writeReg = instrD.i.rt;
        endcase
        if (!rfwe) begin
            writeReg = 5'd0;
        end
    end

endmodule

//--- source/decodeBuffer.sv
module decodeBuffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [31:0]              instr,
    input  logic                     instrValid,
    input  logic                     stall,
    output mipsDecodePkg::instrWord_t instrD,
    output logic                     validD
);

    import mipsDecodePkg::*;

    logic load;

    assign load = instrValid & ~stall;

    always_ff @(posedge clk) begin
        if (load) begin
            instrD <= instrWord_t'(instr);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validD <= 1'b0;
        end else if (!stall) begin
            validD <= instrValid;  // Held while stalled
        end
    end

endmodule

//--- source/mipsDecodePkg.sv
package mipsDecodePkg;

    // Instruction field widths
    localparam int opWidth    = 6;
    localparam int regWidth   = 5;
    localparam int functWidth = 6;
    localparam int immWidth   = 16;

    // Primary opcodes
    localparam logic [5:0] opAddr = 6'h00;  // R-type group
    localparam logic [5:0] opJ    = 6'h02;
    localparam logic [5:0] opJal  = 6'h03;
    localparam logic [5:0] opBeq  = 6'h04;
    localparam logic [5:0] opOri  = 6'h0d;
    localparam logic [5:0] opLui  = 6'h0f;
    localparam logic [5:0] opLw   = 6'h23;
    localparam logic [5:0] opSw   = 6'h2b;

    // Funct codes inside the R-type group
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;

    // ALU operations
    localparam logic [4:0] aluNone = 5'd0;
    localparam logic [4:0] aluAdd  = 5'd1;
    localparam logic [4:0] aluSub  = 5'd2;
    localparam logic [4:0] aluOr   = 5'd3;
    localparam logic [4:0] aluLui  = 5'd4;  // Imm shifted to upper half

    // Compare operations for branch resolution
    localparam logic [3:0] cmpNone  = 4'd0;
    localparam logic [3:0] cmpEqual = 4'd1;

    // Next-PC selection
    localparam logic [2:0] npcSeq    = 3'd0;
    localparam logic [2:0] npcBranch = 3'd1;
    localparam logic [2:0] npcJump   = 3'd2;
    localparam logic [2:0] npcReg    = 3'd3;

    // Destination register source
    localparam logic [1:0] wrSelRt = 2'd0;
    localparam logic [1:0] wrSelRd = 2'd1;
    localparam logic [1:0] wrSelRa = 2'd2;

    localparam logic [2:0] tuseNever = 3'd5;  // Source not read
    localparam logic [4:0] raReg     = 5'd31;

    typedef struct packed {
        logic [opWidth-1:0]    op;
        logic [regWidth-1:0]   rs;
        logic [regWidth-1:0]   rt;
        logic [regWidth-1:0]   rd;
        logic [regWidth-1:0]   shamt;
        logic [functWidth-1:0] funct;
    } rType_t;

    typedef struct packed {
        logic [opWidth-1:0]  op;
        logic [regWidth-1:0] rs;
        logic [regWidth-1:0] rt;
        logic [immWidth-1:0] imm16;
    } iType_t;

    // Same 32-bit word, seen as R-type or I-type
    typedef union packed {
        rType_t r;
        iType_t i;
    } instrWord_t;

endpackage
